//--- Makefile
VERILATOR  ?= verilator
TOP        := decode_unit_tb
FILELIST   := sim.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/ctrl_pkg.sv
package ctrl_pkg;

    typedef logic [31:0] word_t;       // Datapath word
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  lis_op_t;     // Load/store operation
    typedef logic [1:0]  br_op_t;
    typedef logic [1:0]  origin_t;     // Where the execute operands come from
    typedef logic [3:0]  byte_mask_t;  // One bit per byte lane

    // ALU operations
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // Load/store operations, loads first
    localparam lis_op_t LIS_LB  = 3'd0;
    localparam lis_op_t LIS_LH  = 3'd1;
    localparam lis_op_t LIS_LW  = 3'd2;
    localparam lis_op_t LIS_LBU = 3'd3;
    localparam lis_op_t LIS_LHU = 3'd4;
    localparam lis_op_t LIS_SB  = 3'd5;
    localparam lis_op_t LIS_SH  = 3'd6;
    localparam lis_op_t LIS_SW  = 3'd7;

    // Branch conditions, applied to the ALU result
    localparam br_op_t BR_EQ = 2'd0;
    localparam br_op_t BR_NE = 2'd1;
    localparam br_op_t BR_LT = 2'd2;
    localparam br_op_t BR_GE = 2'd3;

    // Operand origin
    localparam origin_t ORIG_REGS    = 2'd0;  // rs1 and rs2
    localparam origin_t ORIG_IMM_RS1 = 2'd1;  // rs1 and immediate
    localparam origin_t ORIG_IMM_PC  = 2'd2;  // PC and immediate

    // Control bundle, all zero is a bubble
    typedef struct packed {
        alu_op_t               alu_op;
        lis_op_t               lis_op;
        br_op_t                br_op;
        origin_t               origin;
        word_t                 imm_val;
        logic                  is_load_store;
        logic                  mem_w;
        logic                  reg_w;
        logic                  is_branch;      // Jumps count as branches
        rv_isa_pkg::reg_addr_t r1_addr;
        rv_isa_pkg::reg_addr_t r2_addr;
        rv_isa_pkg::reg_addr_t rd_addr;
        byte_mask_t            write_mask;     // Stores only
    } ctrl_t;

endpackage

//--- rtl/decode_unit.sv
module decode_unit (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  rv_isa_pkg::instr_t instruction_i,
    input  logic               mem_gnt_i,
    input  logic               mem_rvalid_i,
    output ctrl_pkg::ctrl_t    ex_ctrl_o,
    output logic               mem_req_o,
    output logic               is_stall_o
);
    import rv_isa_pkg::*;
    import ctrl_pkg::*;

    ctrl_t    dec_ctrl;   // Control without immediate
    imm_fmt_t imm_fmt;
    ctrl_t    full_ctrl;  // Complete bundle, ready to issue

    // Opcode class and function fields
    op_decode op_decode_inst (
        .instr_i    (instruction_i),
        .dec_ctrl_o (dec_ctrl),
        .imm_fmt_o  (imm_fmt)
    );

    imm_gen imm_gen_inst (
        .instr_i     (instruction_i),
        .imm_fmt_i   (imm_fmt),
        .dec_ctrl_i  (dec_ctrl),
        .full_ctrl_o (full_ctrl)
    );

    // Only registered stage
    issue_stage issue_stage_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .full_ctrl_i  (full_ctrl),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .ex_ctrl_o    (ex_ctrl_o),
        .mem_req_o    (mem_req_o),
        .is_stall_o   (is_stall_o)
    );

endmodule

//--- rtl/imm_gen.sv
module imm_gen (
    input  rv_isa_pkg::instr_t   instr_i,
    input  rv_isa_pkg::imm_fmt_t imm_fmt_i,
    input  ctrl_pkg::ctrl_t      dec_ctrl_i,
    output ctrl_pkg::ctrl_t      full_ctrl_o
);
    import rv_isa_pkg::*;
    import ctrl_pkg::*;

    word_t imm;
    logic  sign;   // Immediate sign is always the top instruction bit

    assign sign = instr_i[31];

    always_comb begin
        case (imm_fmt_i)
            IMM_I: imm = {{20{sign}}, instr_i[31:20]};
            IMM_S: imm = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: begin
                // Halfword offset, bit 0 implied zero
                imm = {{19{sign}}, sign, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            IMM_U: imm = {instr_i[31:12], 12'b0};   // Upper 20 bits, low 12 cleared
            IMM_J: begin
                imm = {{11{sign}}, sign, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            end
            default: imm = '0;                     // IMM_NONE, R-type and bubbles
        endcase
    end

    // Everything else passes through untouched
    always_comb begin
        full_ctrl_o         = dec_ctrl_i;
        full_ctrl_o.imm_val = imm;
    end

endmodule

//--- rtl/issue_stage.sv
module issue_stage (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  ctrl_pkg::ctrl_t full_ctrl_i,
    input  logic            mem_gnt_i,     // Memory accepted the request
    input  logic            mem_rvalid_i,  // Store completed
    output ctrl_pkg::ctrl_t ex_ctrl_o,
    output logic            mem_req_o,
    output logic            is_stall_o
);
    import ctrl_pkg::*;

    ctrl_t ex_q;          // Issued bundle
    logic  is_load;
    logic  is_store;
    logic  load_wait;
    logic  store_wait;

    // Freeze while the memory side is busy, upstream holds its instruction
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_q <= '0;                // Bubble
        end else if (!is_stall_o) begin
            ex_q <= full_ctrl_i;
        end
    end

    assign is_load  = ex_q.is_load_store && !ex_q.mem_w;
    assign is_store = ex_q.is_load_store && ex_q.mem_w;

    // Loads only need the grant
    assign load_wait = is_load && !mem_gnt_i;

    // Stores need the grant and the write response in the same cycle
    assign store_wait = is_store && !(mem_gnt_i && mem_rvalid_i);

    assign is_stall_o = load_wait || store_wait;
    assign mem_req_o  = ex_q.is_load_store;  // Held for the whole stall
    assign ex_ctrl_o  = ex_q;

endmodule

//--- rtl/op_decode.sv
module op_decode (
    input  rv_isa_pkg::instr_t   instr_i,
    output ctrl_pkg::ctrl_t      dec_ctrl_o,
    output rv_isa_pkg::imm_fmt_t imm_fmt_o
);
    import rv_isa_pkg::*;
    import ctrl_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    logic      funct7_b5;   // SUB and SRA select
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      legal;       // Cleared for anything we do not decode

    // Fixed field positions, the same in every format
    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rs1       = instr_i[19:15];
    assign rs2       = instr_i[24:20];
    assign rd        = instr_i[11:7];

    always_comb begin
        dec_ctrl_o = '0;          // Start from a bubble
        imm_fmt_o  = IMM_NONE;
        legal      = 1'b1;
        case (opcode)
            OPC_LUI: begin                              // rd = 0 + imm
                dec_ctrl_o.origin  = ORIG_IMM_RS1;      // r1_addr stays x0
                dec_ctrl_o.reg_w   = 1'b1;
                dec_ctrl_o.rd_addr = rd;
                imm_fmt_o          = IMM_U;
            end
            OPC_AUIPC: begin                            // rd = pc + imm
                dec_ctrl_o.origin  = ORIG_IMM_PC;
                dec_ctrl_o.reg_w   = 1'b1;
                dec_ctrl_o.rd_addr = rd;
                imm_fmt_o          = IMM_U;
            end
            OPC_JAL: begin
                dec_ctrl_o.is_branch = 1'b1;
                dec_ctrl_o.origin    = ORIG_IMM_PC;     // Target is pc + imm
                dec_ctrl_o.reg_w     = 1'b1;            // Link register
                dec_ctrl_o.rd_addr   = rd;
                imm_fmt_o            = IMM_J;
            end
            OPC_JALR: begin
                dec_ctrl_o.is_branch = 1'b1;
                dec_ctrl_o.origin    = ORIG_IMM_RS1;    // Target is rs1 + imm
                dec_ctrl_o.r1_addr   = rs1;
                dec_ctrl_o.reg_w     = 1'b1;
                dec_ctrl_o.rd_addr   = rd;
                imm_fmt_o            = IMM_I;
            end
            OPC_BRANCH: begin
                dec_ctrl_o.is_branch = 1'b1;
                dec_ctrl_o.origin    = ORIG_REGS;       // Compare rs1 with rs2
                dec_ctrl_o.r1_addr   = rs1;
                dec_ctrl_o.r2_addr   = rs2;
                imm_fmt_o            = IMM_B;
                // EQ/NE look at a zero difference, the rest at the less-than bit
                case (funct3)
                    F3_BEQ:  begin dec_ctrl_o.alu_op = ALU_SUB;  dec_ctrl_o.br_op = BR_EQ; end
                    F3_BNE:  begin dec_ctrl_o.alu_op = ALU_SUB;  dec_ctrl_o.br_op = BR_NE; end
                    F3_BLT:  begin dec_ctrl_o.alu_op = ALU_SLT;  dec_ctrl_o.br_op = BR_LT; end
                    F3_BGE:  begin dec_ctrl_o.alu_op = ALU_SLT;  dec_ctrl_o.br_op = BR_GE; end
                    F3_BLTU: begin dec_ctrl_o.alu_op = ALU_SLTU; dec_ctrl_o.br_op = BR_LT; end
                    F3_BGEU: begin dec_ctrl_o.alu_op = ALU_SLTU; dec_ctrl_o.br_op = BR_GE; end
                    default: legal = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                dec_ctrl_o.is_load_store = 1'b1;
                dec_ctrl_o.origin        = ORIG_IMM_RS1;  // Address is rs1 + imm
                dec_ctrl_o.r1_addr       = rs1;
                dec_ctrl_o.reg_w         = 1'b1;
                dec_ctrl_o.rd_addr       = rd;
                imm_fmt_o                = IMM_I;
                case (funct3)
                    F3_LB:   dec_ctrl_o.lis_op = LIS_LB;
                    F3_LH:   dec_ctrl_o.lis_op = LIS_LH;
                    F3_LW:   dec_ctrl_o.lis_op = LIS_LW;
                    F3_LBU:  dec_ctrl_o.lis_op = LIS_LBU;
                    F3_LHU:  dec_ctrl_o.lis_op = LIS_LHU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                dec_ctrl_o.is_load_store = 1'b1;
                dec_ctrl_o.mem_w         = 1'b1;
                dec_ctrl_o.origin        = ORIG_IMM_RS1;
                dec_ctrl_o.r1_addr       = rs1;           // Base
                dec_ctrl_o.r2_addr       = rs2;           // Store data
                imm_fmt_o                = IMM_S;
                case (funct3)
                    F3_SB: begin
                        dec_ctrl_o.lis_op     = LIS_SB;
                        dec_ctrl_o.write_mask = 4'b0001;
                    end
                    F3_SH: begin
                        dec_ctrl_o.lis_op     = LIS_SH;
                        dec_ctrl_o.write_mask = 4'b0011;
                    end
                    F3_SW: begin
                        dec_ctrl_o.lis_op     = LIS_SW;
                        dec_ctrl_o.write_mask = 4'b1111;
                    end
                    default: legal = 1'b0;
                endcase
            end
            OPC_OP_IMM, OPC_OP: begin
                dec_ctrl_o.reg_w   = 1'b1;
                dec_ctrl_o.r1_addr = rs1;
                dec_ctrl_o.rd_addr = rd;
                if (opcode == OPC_OP) begin
                    dec_ctrl_o.origin  = ORIG_REGS;
                    dec_ctrl_o.r2_addr = rs2;
                end else begin
                    dec_ctrl_o.origin = ORIG_IMM_RS1;
                    imm_fmt_o         = IMM_I;
                end
                case (funct3)
                    // No SUBI, so bit 30 of an ADDI immediate is ignored
                    F3_ADD_SUB: dec_ctrl_o.alu_op = (opcode == OPC_OP && funct7_b5) ?
                                                    ALU_SUB : ALU_ADD;
                    F3_SLL:     dec_ctrl_o.alu_op = ALU_SLL;
                    F3_SLT:     dec_ctrl_o.alu_op = ALU_SLT;
                    F3_SLTU:    dec_ctrl_o.alu_op = ALU_SLTU;
                    F3_XOR:     dec_ctrl_o.alu_op = ALU_XOR;
                    F3_SRL_SRA: dec_ctrl_o.alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec_ctrl_o.alu_op = ALU_OR;
                    default:    dec_ctrl_o.alu_op = ALU_AND;  // Only 3'b111 left
                endcase
            end
            default: legal = 1'b0;  // SYSTEM, FENCE and illegal opcodes
        endcase

        // Anything not understood goes down the pipe as a bubble
        if (!legal) begin
            dec_ctrl_o = '0;
            imm_fmt_o  = IMM_NONE;
        end
    end

endmodule

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // Instruction word and field types
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  reg_addr_t;   // x0..x31
    typedef logic [2:0]  imm_fmt_t;    // Which immediate layout to rebuild

    // Major opcodes, RV32I base only
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // Branch compares
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Load widths, U variants zero extend
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // Store widths
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    // ALU functions, shared by OP and OP_IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;  // funct7[5] picks arithmetic
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Immediate formats
    localparam imm_fmt_t IMM_NONE = 3'd0;
    localparam imm_fmt_t IMM_I    = 3'd1;
    localparam imm_fmt_t IMM_S    = 3'd2;
    localparam imm_fmt_t IMM_B    = 3'd3;
    localparam imm_fmt_t IMM_U    = 3'd4;
    localparam imm_fmt_t IMM_J    = 3'd5;

endpackage

//--- sim.f
rtl/rv_isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/op_decode.sv
rtl/imm_gen.sv
rtl/issue_stage.sv
rtl/decode_unit.sv
verif/decode_unit_sva.sv
verif/decode_unit_tb.sv

//--- verif/decode_unit_sva.sv
module decode_unit_sva (
    input logic            clk_i,
    input logic            rst_n_i,
    input ctrl_pkg::ctrl_t ex_ctrl_o,
    input logic            mem_req_o,
    input logic            is_stall_o
);

    // Request follows the issued bundle
    req_matches_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o == ex_ctrl_o.is_load_store)
        else $error("mem_req_o differs from the issued is_load_store");

    // Stalled bundle must not move
    hold_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        is_stall_o |=> $stable(ex_ctrl_o))
        else $error("ex_ctrl_o changed during a stall");

    quiet_after_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> (!mem_req_o && !is_stall_o))
        else $error("mem_req_o or is_stall_o high right after reset");

endmodule

bind issue_stage decode_unit_sva decode_unit_sva_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ex_ctrl_o  (ex_ctrl_o),
    .mem_req_o  (mem_req_o),
    .is_stall_o (is_stall_o)
);

//--- verif/decode_unit_tb.sv
module decode_unit_tb;
    import rv_isa_pkg::*;
    import ctrl_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;  // All tests need under 300 cycles
    localparam alu_op_t ALU_BY_F3 [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                          ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    localparam opcode_t UPPER_OPCODES [4] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR};

    logic        clk;
    logic        rst_n;
    instr_t      instruction;
    logic        mem_gnt;
    logic        mem_rvalid;
    ctrl_t       ex_ctrl;
    logic        mem_req;
    logic        is_stall;
    logic [31:0] rng_state = 32'h74b1;
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests = 0;

    decode_unit decode_unit_inst (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instruction_i (instruction),
        .mem_gnt_i     (mem_gnt),
        .mem_rvalid_i  (mem_rvalid),
        .ex_ctrl_o     (ex_ctrl),
        .mem_req_o     (mem_req),
        .is_stall_o    (is_stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;  // LCG step
        return rng_state;
    endfunction

    // Sign extend from bit (bits - 1)
    function automatic word_t sext(input word_t v, input int bits);
        word_t m;
        m = 32'h1 << (bits - 1);
        return (v ^ m) - m;
    endfunction

    function automatic logic known_opcode(input opcode_t op);
        return op inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                          OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};
    endfunction

    // Reference decode from the RV32I encoding
    function automatic ctrl_t expect_ctrl(input instr_t w);
        ctrl_t      e;
        funct3_t    f3;
        logic       ok;
        logic [2:0] regs_used;   // rd, rs1, rs2
        e         = '0;
        f3        = w[14:12];
        ok        = 1'b1;
        regs_used = 3'b100;
        case (w[6:0])
            OPC_LUI, OPC_AUIPC: begin
                e.origin  = (w[6:0] == OPC_LUI) ? ORIG_IMM_RS1 : ORIG_IMM_PC;
                e.imm_val = {w[31:12], 12'h000};
            end
            OPC_JAL: begin
                e.is_branch = 1'b1;
                e.origin    = ORIG_IMM_PC;
                e.imm_val   = sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
            end
            OPC_JALR: begin
                e.is_branch = 1'b1;
                e.origin    = ORIG_IMM_RS1;
                e.imm_val   = sext(32'(w[31:20]), 12);
                regs_used   = 3'b110;
            end
            OPC_BRANCH: begin
                ok          = f3[2:1] != 2'b01;
                e.is_branch = 1'b1;
                e.alu_op    = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
                e.br_op     = {f3[2], f3[0]};
                e.imm_val   = sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
                regs_used   = 3'b011;
            end
            OPC_LOAD: begin
                ok              = f3 != 3'd3 && f3 < 3'd6;
                e.is_load_store = 1'b1;
                e.lis_op        = f3[2] ? f3 - 3'd1 : f3;   // LBU and LHU follow LW
                e.origin        = ORIG_IMM_RS1;
                e.imm_val       = sext(32'(w[31:20]), 12);
                regs_used       = 3'b110;
            end
            OPC_STORE: begin
                ok              = f3 < 3'd3;
                e.is_load_store = 1'b1;
                e.mem_w         = 1'b1;
                e.lis_op        = f3 + 3'd5;
                e.origin        = ORIG_IMM_RS1;
                e.write_mask    = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
                e.imm_val       = sext(32'({w[31:25], w[11:7]}), 12);
                regs_used       = 3'b011;
            end
            OPC_OP, OPC_OP_IMM: begin
                e.alu_op = ALU_BY_F3[f3];
                // Bit 5 of the opcode marks register-register
                if (w[30] && (f3 == 3'd5 || (f3 == 3'd0 && w[5]))) begin
                    e.alu_op = (f3 == 3'd5) ? ALU_SRA : ALU_SUB;
                end
                e.origin  = w[5] ? ORIG_REGS : ORIG_IMM_RS1;
                e.imm_val = w[5] ? 32'h0 : sext(32'(w[31:20]), 12);
                regs_used = w[5] ? 3'b111 : 3'b110;
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            return '0;
        end
        e.reg_w   = regs_used[2];
        e.rd_addr = regs_used[2] ? w[11:7] : 5'd0;
        e.r1_addr = regs_used[1] ? w[19:15] : 5'd0;
        e.r2_addr = regs_used[0] ? w[24:20] : 5'd0;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_bundle(input ctrl_t exp);
        check_value("ex_ctrl_o.alu_op", 32'(ex_ctrl.alu_op), 32'(exp.alu_op));
        check_value("ex_ctrl_o.lis_op", 32'(ex_ctrl.lis_op), 32'(exp.lis_op));
        check_value("ex_ctrl_o.br_op", 32'(ex_ctrl.br_op), 32'(exp.br_op));
        check_value("ex_ctrl_o.origin", 32'(ex_ctrl.origin), 32'(exp.origin));
        check_value("ex_ctrl_o.imm_val", ex_ctrl.imm_val, exp.imm_val);
        check_value("ex_ctrl_o.is_load_store", 32'(ex_ctrl.is_load_store),
                    32'(exp.is_load_store));
        check_value("ex_ctrl_o.mem_w", 32'(ex_ctrl.mem_w), 32'(exp.mem_w));
        check_value("ex_ctrl_o.reg_w", 32'(ex_ctrl.reg_w), 32'(exp.reg_w));
        check_value("ex_ctrl_o.is_branch", 32'(ex_ctrl.is_branch), 32'(exp.is_branch));
        check_value("ex_ctrl_o.r1_addr", 32'(ex_ctrl.r1_addr), 32'(exp.r1_addr));
        check_value("ex_ctrl_o.r2_addr", 32'(ex_ctrl.r2_addr), 32'(exp.r2_addr));
        check_value("ex_ctrl_o.rd_addr", 32'(ex_ctrl.rd_addr), 32'(exp.rd_addr));
        check_value("ex_ctrl_o.write_mask", 32'(ex_ctrl.write_mask), 32'(exp.write_mask));
        check_value("mem_req_o", 32'(mem_req), 32'(exp.is_load_store));
    endtask

    // One cycle from instruction to issued bundle
    task automatic issue_and_check(input instr_t w, input ctrl_t exp);
        @(posedge clk);
        instruction <= w;
        @(posedge clk);          // Captured here
        @(negedge clk);
        check_bundle(exp);
        check_value("is_stall_o", 32'(is_stall), 32'd0);
    endtask

    task automatic issue_random(input opcode_t opc, input funct3_t f3, input logic alt);
        instr_t w;
        w        = next_rand();
        w[6:0]   = opc;
        w[14:12] = f3;
        w[30]    = alt;
        issue_and_check(w, expect_ctrl(w));
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic hold_stalled(input instr_t w, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bundle(expect_ctrl(w));
            check_value("is_stall_o", 32'(is_stall), 32'd1);
            @(posedge clk);
        end
    endtask

    task automatic test_reset();
        repeat (7) begin
            @(posedge clk);
            @(negedge clk);
            check_bundle('0);    // Pending LW without grant must not stall
            check_value("is_stall_o", 32'(is_stall), 32'd0);
        end
        @(posedge clk);          // Eighth edge still in reset
        rst_n       <= 1'b1;
        instruction <= 32'h0000_0013;   // ADDI x0, x0, 0
        mem_gnt     <= 1'b1;
        mem_rvalid  <= 1'b1;
        @(negedge clk);
        check_bundle('0);
        check_value("is_stall_o", 32'(is_stall), 32'd0);
        end_test("reset");
    endtask

    task automatic test_alu();
        for (int i = 0; i < 32; i++) begin
            issue_random(i[4] ? OPC_OP : OPC_OP_IMM, i[2:0], i[3]);
        end
        end_test("alu");
    endtask

    task automatic test_upper();
        logic [31:0] r;
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            issue_random(UPPER_OPCODES[i[1:0]], (i[1:0] == 2'd3) ? 3'd0 : r[2:0], r[3]);
        end
        end_test("upper_jump");
    endtask

    task automatic test_branch();
        for (int i = 0; i < 16; i++) begin
            if (i[2:1] != 2'b01) begin   // Skip the two unused codes
                issue_random(OPC_BRANCH, i[2:0], i[3]);
            end
        end
        end_test("branch");
    endtask

    // Grant and rvalid released one at a time, hold length chosen per access
    task automatic mem_access(input opcode_t opc, input funct3_t f3);
        instr_t w;
        instr_t next_w;
        int     hold;
        logic   store;
        w        = next_rand();
        w[6:0]   = opc;
        w[14:12] = f3;
        next_w   = next_rand();
        next_w[6:0] = OPC_OP_IMM;
        hold     = 1 + int'(next_rand() % 3);
        store    = (opc == OPC_STORE);
        @(posedge clk);
        instruction <= w;
        @(posedge clk);          // w issued here
        instruction <= next_w;   // Waits behind the stall
        mem_gnt     <= 1'b0;
        mem_rvalid  <= 1'b1;     // Valid alone must not free a store
        hold_stalled(w, hold);
        mem_gnt    <= 1'b1;      // Frees a load, a store still waits
        mem_rvalid <= 1'b0;
        if (store) begin
            hold_stalled(w, hold);
            mem_rvalid <= 1'b1;
        end
        @(negedge clk);
        check_bundle(expect_ctrl(w));
        check_value("is_stall_o", 32'(is_stall), 32'd0);
        @(posedge clk);
        mem_rvalid <= 1'b1;
        @(negedge clk);
        check_bundle(expect_ctrl(next_w));
    endtask

    task automatic test_mem();
        for (int i = 0; i < 6; i++) begin
            if (i != 3) begin
                mem_access(OPC_LOAD, i[2:0]);
            end
        end
        for (int i = 0; i < 3; i++) begin
            mem_access(OPC_STORE, i[2:0]);
        end
        end_test("load_store");
    endtask

    task automatic test_illegal();
        instr_t w;
        for (int i = 0; i < 16; i++) begin
            w = next_rand();
            case (i)
                0: w[6:0] = 7'b1110011;          // SYSTEM
                1: w[6:0] = 7'b0001111;          // FENCE
                3, 6, 7: begin
                    w[6:0]   = OPC_LOAD;
                    w[14:12] = i[2:0];           // Unused load widths
                end
                default: begin
                    while (known_opcode(w[6:0])) begin
                        w = next_rand();
                    end
                end
            endcase
            issue_and_check(w, '0);
        end
        end_test("illegal");
    endtask

    initial begin
        rst_n       = 1'b0;
        instruction = 32'h0000_2003;   // LW x0, 0(x0)
        mem_gnt     = 1'b0;
        mem_rvalid  = 1'b0;
        test_reset();
        test_alu();
        test_upper();
        test_branch();
        test_mem();
        test_illegal();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
